//--- common/spi_frame_pkg.sv
// package spi_frame_pkg
// host frame layout, address and data types
// write command struct carried through the queue

package spi_frame_pkg;

  // frame length in sclk bits
  localparam int FRAME_BITS = 16;

  // read flag is the first bit out of the host
  localparam int RD_BIT = FRAME_BITS - 1;

  // low byte of the frame
  localparam int DATA_BITS = 8;

  typedef logic [FRAME_BITS-1:0] frame_t;
  typedef logic [DATA_BITS-1:0]  data_t;

  // frame address is the register address
  typedef spi_regs_pkg::reg_addr_t addr_t;

  // one host write, waits in the queue
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_cmd_t;

endpackage

//--- common/spi_regs_pkg.sv
// package spi_regs_pkg
// register addresses and register value types
// register snapshot struct with its reset value

package spi_regs_pkg;

  ////////////////////
  // value types

  // 4 bit set/clear register
  typedef logic [3:0] nib_t;

  // spi mux value, 0 is no line, n is line n-1
  typedef logic [7:0] mux_t;

  // read only status byte
  typedef logic [7:0] status_t;

  // 7 bit register address from the frame
  typedef logic [6:0] reg_addr_t;

  ////////////////////
  // register map

  localparam reg_addr_t ADDR_POWERUP    = 7'd6;
  localparam reg_addr_t ADDR_LED        = 7'd7;
  localparam reg_addr_t ADDR_SPI_MUX    = 7'd8;
  localparam reg_addr_t ADDR_4094       = 7'd9;
  localparam reg_addr_t ADDR_SOFT_RESET = 7'd11;
  localparam reg_addr_t ADDR_ADC        = 7'd14;
  localparam reg_addr_t ADDR_STATUS     = 7'd15;

  // sticky overflow flag in status
  localparam int STATUS_OVF = 0;

  ////////////////////
  // current register values

  typedef struct packed {
    nib_t    led;
    mux_t    spi_mux;
    nib_t    out4094;
    nib_t    adc;
    status_t status;
  } reg_snap_t;

  // led comes up with bit 0 lit
  localparam nib_t LED_RESET = 4'b0001;

  localparam reg_snap_t SNAP_RESET = '{
    led:     LED_RESET,
    spi_mux: '0,
    out4094: '0,
    adc:     '0,
    status:  '0
  };

endpackage

//--- dv/spi_ctrl_assert.sv
// module spi_ctrl_assert
// concurrent checks on the write queue strobes and the peripheral routing

`timescale 1ns/100ps

module spi_ctrl_assert
  import spi_regs_pkg::*;
#(
  parameter int                    NUM_PERIPH  = 8,
  parameter logic [NUM_PERIPH-1:0] CS_POLARITY = NUM_PERIPH'(1)
)
(
  input logic                  cs,
  input logic                  rst_n,
  input logic                  push,
  input logic                  pop,
  input logic                  empty,
  input logic                  overflow,
  input mux_t                  spi_mux,
  input logic                  spi_ss2_n,
  input logic [NUM_PERIPH-1:0] periph_cs,
  input logic [NUM_PERIPH-1:0] periph_sclk,
  input logic [NUM_PERIPH-1:0] periph_mosi
);

  // select bit of line 0, shifted up to the named line
  localparam logic [NUM_PERIPH-1:0] LINE0 = NUM_PERIPH'(1);

  // mux value names one of the lines
  logic mux_on;

  assign mux_on = (spi_mux != '0) && (spi_mux <= mux_t'(NUM_PERIPH));

  ////////////////////
  // queue

  // no pop unless pass-through was idle two samples back
  a_pop_idle: assert property (@(posedge cs) disable iff (!rst_n)
    pop |-> $past(spi_ss2_n, 2))
    else $error("queue popped during a pass-through transfer");

  // a dropped write leaves the queue holding entries
  a_ovf_not_empty: assert property (@(posedge cs) disable iff (!rst_n)
    overflow |-> !empty)
    else $error("overflow pulse with an empty queue");

  // strobes quiet in the first cycle out of reset
  a_reset_quiet: assert property (@(posedge cs) $rose(rst_n) |-> !push && !pop && !overflow)
    else $error("queue strobes active right after reset");

  ////////////////////
  // routing

  // mux n puts line n-1 at its active level and leaves the rest idle
  a_line_cs: assert property (@(posedge cs) disable iff (!rst_n)
    (!spi_ss2_n && mux_on) |->
      (periph_cs == (~CS_POLARITY ^ (LINE0 << (spi_mux - 1'b1)))))
    else $error("wrong peripheral select for the mux value");

  // clock and data only on the named line
  a_line_clk: assert property (@(posedge cs) disable iff (!rst_n)
    mux_on |-> (((periph_sclk | periph_mosi) & ~(LINE0 << (spi_mux - 1'b1))) == '0))
    else $error("clock or data on a line the mux does not name");

  // every line idle and quiet when the mux names none
  a_no_line: assert property (@(posedge cs) disable iff (!rst_n)
    !mux_on |-> (periph_cs == ~CS_POLARITY) && (periph_sclk == '0) && (periph_mosi == '0))
    else $error("peripheral line driven with no line selected");

endmodule

//--- dv/spi_ctrl_tb.sv
// module spi_ctrl_tb
// clock, reset, spi host and pass-through tasks, peripheral model,
// reference register model, stimulus table, checks and timeout

`timescale 1ns/100ps

module spi_ctrl_tb
  import spi_regs_pkg::*;
();

  localparam int               QUEUE_DEPTH = 4;
  localparam int               NUM_PERIPH  = 8;
  localparam logic [7:0]       CS_POL      = 8'b0000_0001;
  // base answer of the peripherals
  localparam logic [7:0]       PERIPH_BYTE = 8'hA5;

  typedef enum {OP_RD, OP_WR, OP_SHORT, OP_PT, OP_HOLD, OP_REL} op_t;

  logic cs;
  logic rst_n;
  logic spi_sclk;
  logic spi_ss_n;
  logic spi_ss2_n;
  logic spi_mosi;
  logic spi_miso;
  logic [NUM_PERIPH-1:0] periph_cs;
  logic [NUM_PERIPH-1:0] periph_sclk;
  logic [NUM_PERIPH-1:0] periph_mosi;
  logic [NUM_PERIPH-1:0] periph_miso;
  nib_t led;
  nib_t out4094;
  nib_t adc_ctl;

  // stimulus table columns
  // data -1 means random data
  // expected -1 means the model value
  string t_name[$];
  op_t   t_op[$];
  int    t_addr[$];
  int    t_data[$];
  int    t_exp[$];

  // reference registers and writes held back by pass-through
  nib_t       m_led;
  logic [7:0] m_mux;
  nib_t       m_4094;
  nib_t       m_adc;
  logic [7:0] m_status;
  logic [6:0] q_addr[$];
  logic [7:0] q_data[$];

  string       cur_name;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles;
  int          cycle_limit;
  int          pt_bit;
  logic [7:0]  line_bytes [NUM_PERIPH];

  spi_ctrl_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .NUM_PERIPH  (NUM_PERIPH),
    .CS_POLARITY (CS_POL)
  ) spi_ctrl_top_i (
    .cs          (cs),
    .rst_n       (rst_n),
    .spi_sclk    (spi_sclk),
    .spi_ss_n    (spi_ss_n),
    .spi_ss2_n   (spi_ss2_n),
    .spi_mosi    (spi_mosi),
    .spi_miso    (spi_miso),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_miso (periph_miso),
    .led         (led),
    .out4094     (out4094),
    .adc_ctl     (adc_ctl)
  );

  // queue and routing nets live at the top level
  bind spi_ctrl_top spi_ctrl_assert #(
    .NUM_PERIPH  (NUM_PERIPH),
    .CS_POLARITY (CS_POLARITY)
  ) spi_ctrl_assert_i (
    .cs          (cs),
    .rst_n       (rst_n),
    .push        (push),
    .pop         (pop),
    .empty       (empty),
    .overflow    (overflow),
    .spi_mux     (snap.spi_mux),
    .spi_ss2_n   (spi_ss2_n),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi)
  );

  initial
  begin
    cs = 1'b0;
    forever #20 cs = ~cs;
  end

  // each line answers with its own byte msb first
  always_comb
  begin
    for (int k = 0; k < NUM_PERIPH; k++)
      periph_miso[k] = line_bytes[k][7 - pt_bit];
  end

  // run limit
  always @(posedge cs)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("timeout, run passed its limit of %0d cycles", cycle_limit);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////
  // reference model

  // overlapping bits toggle and nothing else changes
  // without overlap the low nibble sets and the high nibble clears
  function automatic nib_t rule_nib(input nib_t old, input logic [7:0] d);
    nib_t both;
    both = d[3:0] & d[7:4];
    if (both != 4'h0)
      return old ^ both;
    return (old & ~d[7:4]) | d[3:0];
  endfunction

  task automatic model_write(input logic [6:0] a, input logic [7:0] d);
    case (a)
      ADDR_LED:     m_led = rule_nib(m_led, d);
      ADDR_SPI_MUX: m_mux = d;
      ADDR_4094:    m_4094 = rule_nib(m_4094, d);
      ADDR_ADC:     m_adc = rule_nib(m_adc, d);
      ADDR_SOFT_RESET:
      begin
        m_led    = 4'h0;
        m_mux    = 8'h00;
        m_adc    = 4'h0;
        m_status = 8'h00;
      end
      ADDR_POWERUP:
      begin
        m_led = 4'h0;
        m_adc = 4'h0;
      end
      default: ;
    endcase
  endtask

  function automatic logic [7:0] model_read(input logic [6:0] a);
    case (a)
      ADDR_LED:     return {4'h0, m_led};
      ADDR_SPI_MUX: return m_mux;
      ADDR_4094:    return {4'h0, m_4094};
      ADDR_ADC:     return {4'h0, m_adc};
      ADDR_STATUS:  return m_status;
      default:      return 8'h00;
    endcase
  endfunction

  ////////////////////
  // host side

  task automatic check_val(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act)
    begin
      $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic add_row(input string name, input op_t op, input int addr,
                         input int data, input int exp);
    t_name.push_back(name);
    t_op.push_back(op);
    t_addr.push_back(addr);
    t_data.push_back(data);
    t_exp.push_back(exp);
  endtask

  // 8 cs cycles per sclk period
  // miso taken mid high phase
  task automatic host_frame(input logic [15:0] frame, input int nbits, output logic [7:0] rd);
    int b;
    rd = 8'h00;
    @(posedge cs);
    spi_ss_n <= 1'b0;
    for (b = 0; b < nbits; b++)
    begin
      spi_mosi <= frame[15 - b];
      repeat (4) @(posedge cs);
      spi_sclk <= 1'b1;
      repeat (2) @(posedge cs);
      @(negedge cs);
      // readback rides on bits 9 to 16
      if (b >= 8)
        rd = {rd[6:0], spi_miso};
      repeat (2) @(posedge cs);
      spi_sclk <= 1'b0;
    end
    repeat (4) @(posedge cs);
    spi_ss_n <= 1'b1;
    spi_mosi <= 1'b0;
    // push and apply settle within 7 cycles
    repeat (10) @(posedge cs);
  endtask

  // one byte through the second select
  // lines checked on every bit
  task automatic pass_xfer();
    logic [7:0] pattern;
    logic [7:0] sel;
    logic [7:0] exp_byte;
    logic [7:0] rd;
    int b;
    pattern  = 8'h96;
    sel      = 8'h00;
    exp_byte = 8'h00;
    rd       = 8'h00;
    if (m_mux >= 1 && m_mux <= NUM_PERIPH)
    begin
      sel[m_mux - 1] = 1'b1;
      exp_byte       = line_bytes[m_mux - 1];
    end
    check_val("idle periph_cs", ~CS_POL, periph_cs);
    @(posedge cs);
    spi_ss2_n <= 1'b0;
    for (b = 0; b < 8; b++)
    begin
      pt_bit   <= b;
      spi_mosi <= pattern[7 - b];
      repeat (4) @(posedge cs);
      spi_sclk <= 1'b1;
      repeat (2) @(posedge cs);
      @(negedge cs);
      rd = {rd[6:0], spi_miso};
      // named line at its polarity and the rest idle
      check_val("periph_cs", (CS_POL & sel) | (~CS_POL & ~sel), periph_cs);
      check_val("periph_sclk", sel, periph_sclk);
      check_val("periph_mosi", pattern[7 - b] ? sel : 8'h00, periph_mosi);
      repeat (2) @(posedge cs);
      spi_sclk <= 1'b0;
    end
    repeat (4) @(posedge cs);
    spi_ss2_n <= 1'b1;
    spi_mosi  <= 1'b0;
    pt_bit    <= 0;
    repeat (8) @(posedge cs);
    check_val("pass-through miso", exp_byte, rd);
  endtask

  task automatic run_row(input op_t op, input int addr, input int data, input int exp);
    logic [6:0] a;
    logic [7:0] d;
    logic [7:0] rd;
    logic [7:0] want;
    a = addr[6:0];
    d = (data < 0) ? 8'($urandom % 256) : data[7:0];
    case (op)
      OP_RD:
      begin
        host_frame({1'b1, a, 8'h00}, 16, rd);
        want = (exp >= 0) ? exp[7:0] : model_read(a);
        check_val("readback", want, rd);
      end
      OP_WR:
      begin
        host_frame({1'b0, a, d}, 16, rd);
        model_write(a, d);
      end
      // 12 bit frame is thrown away
      OP_SHORT: host_frame({1'b0, a, d}, 12, rd);
      OP_PT:    pass_xfer();
      OP_HOLD:
      begin
        @(posedge cs);
        spi_ss2_n <= 1'b0;
        host_frame({1'b0, a, d}, 16, rd);
        if (q_addr.size() < QUEUE_DEPTH)
        begin
          q_addr.push_back(a);
          q_data.push_back(d);
        end
        else
          m_status[0] = 1'b1;
      end
      OP_REL:
      begin
        @(posedge cs);
        spi_ss2_n <= 1'b1;
        // sync plus one pop per queued write
        repeat (12) @(posedge cs);
        while (q_addr.size() > 0)
          model_write(q_addr.pop_front(), q_data.pop_front());
      end
      default: ;
    endcase
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    int i;
    rst_n     = 1'b0;
    spi_sclk  = 1'b0;
    spi_ss_n  = 1'b1;
    spi_ss2_n = 1'b1;
    spi_mosi  = 1'b0;
    pt_bit    = 0;
    cycles    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    void'($urandom(5));
    for (i = 0; i < NUM_PERIPH; i++)
      line_bytes[i] = PERIPH_BYTE ^ 8'(i);
    // reset values
    m_led    = 4'b0001;
    m_mux    = 8'h00;
    m_4094   = 4'h0;
    m_adc    = 4'h0;
    m_status = 8'h00;

    add_row("reset_led", OP_RD, ADDR_LED, 0, 8'h01);
    add_row("reset_mux", OP_RD, ADDR_SPI_MUX, 0, 8'h00);
    add_row("reset_4094", OP_RD, ADDR_4094, 0, 8'h00);
    add_row("reset_adc", OP_RD, ADDR_ADC, 0, 8'h00);
    add_row("reset_status", OP_RD, ADDR_STATUS, 0, 8'h00);
    add_row("led_set", OP_WR, ADDR_LED, 8'h06, -1);
    add_row("led_clear", OP_WR, ADDR_LED, 8'h10, -1);
    add_row("led_toggle", OP_WR, ADDR_LED, 8'h33, -1);
    add_row("led_read", OP_RD, ADDR_LED, 0, -1);
    add_row("out4094_set", OP_WR, ADDR_4094, 8'h0F, -1);
    add_row("out4094_random", OP_WR, ADDR_4094, -1, -1);
    add_row("out4094_read", OP_RD, ADDR_4094, 0, -1);
    add_row("adc_random", OP_WR, ADDR_ADC, -1, -1);
    add_row("adc_random2", OP_WR, ADDR_ADC, -1, -1);
    add_row("adc_read", OP_RD, ADDR_ADC, 0, -1);
    add_row("led_random", OP_WR, ADDR_LED, -1, -1);
    add_row("short_frame", OP_SHORT, ADDR_LED, 8'h0F, -1);
    add_row("short_read", OP_RD, ADDR_LED, 0, -1);
    add_row("powerup", OP_WR, ADDR_POWERUP, 8'h00, -1);
    add_row("powerup_read", OP_RD, ADDR_4094, 0, -1);
    add_row("led_after_pwr", OP_WR, ADDR_LED, 8'h0C, -1);
    add_row("mux_line3", OP_WR, ADDR_SPI_MUX, 8'h03, -1);
    add_row("route_line3", OP_PT, 0, 0, -1);
    add_row("mux_line1", OP_WR, ADDR_SPI_MUX, 8'h01, -1);
    add_row("route_line1", OP_PT, 0, 0, -1);
    add_row("mux_read", OP_RD, ADDR_SPI_MUX, 0, -1);
    add_row("soft_reset", OP_WR, ADDR_SOFT_RESET, 8'h00, -1);
    add_row("route_idle", OP_PT, 0, 0, -1);
    add_row("hold_led", OP_HOLD, ADDR_LED, 8'h0A, -1);
    add_row("hold_4094", OP_HOLD, ADDR_4094, 8'h05, -1);
    add_row("hold_adc", OP_HOLD, ADDR_ADC, 8'h03, -1);
    add_row("hold_mux", OP_HOLD, ADDR_SPI_MUX, 8'h02, -1);
    add_row("hold_lost", OP_HOLD, ADDR_LED, 8'h01, -1);
    add_row("release", OP_REL, 0, 0, -1);
    add_row("overflow_read", OP_RD, ADDR_STATUS, 0, 8'h01);
    add_row("mux_after", OP_RD, ADDR_SPI_MUX, 0, -1);
    add_row("led_after", OP_RD, ADDR_LED, 0, -1);
    add_row("soft_reset2", OP_WR, ADDR_SOFT_RESET, 8'h00, -1);
    add_row("status_clear", OP_RD, ADDR_STATUS, 0, 8'h00);
    cycle_limit = t_name.size() * 200 + 500;

    // 5 cycles of reset
    repeat (5) @(posedge cs);
    rst_n <= 1'b1;
    repeat (2) @(posedge cs);

    for (i = 0; i < t_name.size(); i++)
    begin
      cur_name  = t_name[i];
      test_errs = 0;
      run_row(t_op[i], t_addr[i], t_data[i], t_exp[i]);
      // board outputs follow the model after every row
      check_val("led port", {4'h0, m_led}, {4'h0, led});
      check_val("out4094 port", {4'h0, m_4094}, {4'h0, out4094});
      check_val("adc_ctl port", {4'h0, m_adc}, {4'h0, adc_ctl});
      if (test_errs == 0)
      begin
        pass_cnt++;
        $display("test %s: ok", cur_name);
      end
      else
      begin
        fail_cnt++;
        $display("test %s: %0d mismatches", cur_name, test_errs);
      end
    end

    $display("%0d tests, %0d passed, %0d failed", t_name.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

//--- files.f
common/spi_regs_pkg.sv
common/spi_frame_pkg.sv
spi_frame/spi_frame_rx.sv
source/cmd_queue.sv
source/reg_bank.sv
source/spi_route.sv
source/spi_ctrl_top.sv
dv/spi_ctrl_assert.sv
dv/spi_ctrl_tb.sv

//--- source/cmd_queue.sv
// module cmd_queue
// circular buffer of write commands with full/empty levels
// and a one cycle overflow pulse

`timescale 1ns/100ps

module cmd_queue
  import spi_frame_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
)
(
  input  logic    cs,
  input  logic    rst_n,
  input  logic    push,
  input  wr_cmd_t cmd,
  input  logic    pop,
  output wr_cmd_t head,
  output logic    full,
  output logic    empty,
  output logic    overflow
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  wr_cmd_t          mem [QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  logic             do_push;
  logic             do_pop;

  // wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(logic [PTR_W-1:0] p);
    if (p == PTR_W'(QUEUE_DEPTH - 1))
      ptr_inc = '0;
    else
      ptr_inc = p + 1'b1;
  endfunction

  assign full    = (fill == CNT_W'(QUEUE_DEPTH));
  assign empty   = (fill == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // oldest entry, readable the cycle after its push
  assign head = mem[rd_ptr];

  always_ff @(posedge cs)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= cmd;
    end
  end

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fill     <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      // push into full queue is dropped
      overflow <= push && full;
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

endmodule

//--- source/reg_bank.sv
// module reg_bank
// applies queued writes with the set/clear/toggle rule,
// soft reset and power-up clears, sticky overflow status

`timescale 1ns/100ps

module reg_bank
  import spi_regs_pkg::*, spi_frame_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  wr_cmd_t   head,
  input  logic      empty,
  input  logic      overflow,
  input  logic      spi_ss2_n,
  output logic      pop,
  output reg_snap_t snap
);

  logic [1:0] ss2_sync;
  logic       passthru_idle;

  // low nibble sets, high nibble clears, both together toggle
  function automatic nib_t apply_rule(nib_t old, data_t d);
    nib_t set_bits;
    nib_t clr_bits;
    set_bits = d[3:0];
    clr_bits = d[7:4];
    if (|(set_bits & clr_bits))
      apply_rule = old ^ (set_bits & clr_bits);
    else
      apply_rule = (old | set_bits) & ~clr_bits;
  endfunction

  ////////////////////
  // pass-through guard

  // pass-through select, idles high
  always_ff @(posedge cs)
  begin
    if (!rst_n)
      ss2_sync <= 2'b11;
    else
      ss2_sync <= {ss2_sync[0], spi_ss2_n};
  end

  assign passthru_idle = ss2_sync[1];

  // mux and outputs only move between peripheral transfers
  assign pop = !empty && passthru_idle;

  ////////////////////
  // register update

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      snap <= SNAP_RESET;
    end
    else
    begin
      if (pop)
      begin
        case (head.addr)
          ADDR_LED:
            snap.led <= apply_rule(snap.led, head.data);
          // mux is a plain byte
          ADDR_SPI_MUX:
            snap.spi_mux <= mux_t'(head.data);
          ADDR_4094:
            snap.out4094 <= apply_rule(snap.out4094, head.data);
          ADDR_ADC:
            snap.adc <= apply_rule(snap.adc, head.data);
          ADDR_SOFT_RESET:
          begin
            snap.led     <= '0;
            snap.spi_mux <= '0;
            snap.adc     <= '0;
            snap.status  <= '0;
          end
          // 4094 and mux untouched here
          ADDR_POWERUP:
          begin
            snap.led <= '0;
            snap.adc <= '0;
          end
          // status is read only
          default:
          begin
            snap <= snap;
          end
        endcase
      end
      // sticky, wins over a soft reset in the same cycle
      if (overflow)
      begin
        snap.status[STATUS_OVF] <= 1'b1;
      end
    end
  end

endmodule

//--- source/spi_ctrl_top.sv
// module spi_ctrl_top
// frame receiver, write queue, register bank and spi routing

`timescale 1ns/100ps

module spi_ctrl_top
  import spi_regs_pkg::*, spi_frame_pkg::*;
#(
  parameter int                    QUEUE_DEPTH = 4,
  parameter int                    NUM_PERIPH  = 8,
  parameter logic [NUM_PERIPH-1:0] CS_POLARITY = NUM_PERIPH'(1)
)
(
  input  logic                  cs,
  input  logic                  rst_n,
  // host port
  input  logic                  spi_sclk,
  input  logic                  spi_ss_n,
  input  logic                  spi_ss2_n,
  input  logic                  spi_mosi,
  output logic                  spi_miso,
  // peripheral lines
  output logic [NUM_PERIPH-1:0] periph_cs,
  output logic [NUM_PERIPH-1:0] periph_sclk,
  output logic [NUM_PERIPH-1:0] periph_mosi,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  // board outputs
  output nib_t                  led,
  output nib_t                  out4094,
  output nib_t                  adc_ctl
);

  logic      push;
  logic      pop;
  logic      empty;
  logic      overflow;
  logic      miso_bit;
  wr_cmd_t   cmd;
  wr_cmd_t   head;
  reg_snap_t snap;

  ////////////////////
  // producer

  spi_frame_rx spi_frame_rx_i (
    .cs       (cs),
    .rst_n    (rst_n),
    .spi_sclk (spi_sclk),
    .spi_ss_n (spi_ss_n),
    .spi_mosi (spi_mosi),
    .snap     (snap),
    .miso_bit (miso_bit),
    .push     (push),
    .cmd      (cmd)
  );

  ////////////////////
  // buffer

  // full level stays local, overflow carries the drop
  cmd_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) cmd_queue_i (
    .cs       (cs),
    .rst_n    (rst_n),
    .push     (push),
    .cmd      (cmd),
    .pop      (pop),
    .head     (head),
    .full     (),
    .empty    (empty),
    .overflow (overflow)
  );

  ////////////////////
  // consumer

  reg_bank reg_bank_i (
    .cs        (cs),
    .rst_n     (rst_n),
    .head      (head),
    .empty     (empty),
    .overflow  (overflow),
    .spi_ss2_n (spi_ss2_n),
    .pop       (pop),
    .snap      (snap)
  );

  spi_route #(
    .NUM_PERIPH  (NUM_PERIPH),
    .CS_POLARITY (CS_POLARITY)
  ) spi_route_i (
    .spi_mux     (snap.spi_mux),
    .spi_ss2_n   (spi_ss2_n),
    .spi_sclk    (spi_sclk),
    .spi_mosi    (spi_mosi),
    .miso_bit    (miso_bit),
    .periph_miso (periph_miso),
    .periph_cs   (periph_cs),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .spi_miso    (spi_miso)
  );

  // register fields straight to the board
  assign led     = snap.led;
  assign out4094 = snap.out4094;
  assign adc_ctl = snap.adc;

endmodule

//--- source/spi_route.sv
// module spi_route
// mux register decode onto peripheral lines with cs polarity,
// miso return select

`timescale 1ns/100ps

module spi_route
  import spi_regs_pkg::*;
#(
  parameter int                    NUM_PERIPH  = 8,
  parameter logic [NUM_PERIPH-1:0] CS_POLARITY = NUM_PERIPH'(1)
)
(
  input  mux_t                  spi_mux,
  input  logic                  spi_ss2_n,
  input  logic                  spi_sclk,
  input  logic                  spi_mosi,
  input  logic                  miso_bit,
  input  logic [NUM_PERIPH-1:0] periph_miso,
  output logic [NUM_PERIPH-1:0] periph_cs,
  output logic [NUM_PERIPH-1:0] periph_sclk,
  output logic [NUM_PERIPH-1:0] periph_mosi,
  output logic                  spi_miso
);

  // one hot selected line, none for mux 0 or out of range
  logic [NUM_PERIPH-1:0] line_sel;
  logic [NUM_PERIPH-1:0] line_cs;

  genvar i;
  generate
    for (i = 0; i < NUM_PERIPH; i++)
    begin : g_decode
      assign line_sel[i] = (spi_mux == mux_t'(i + 1));
    end
  endgenerate

  // asserted select on the active line only
  assign line_cs = line_sel & {NUM_PERIPH{~spi_ss2_n}};

  // polarity 1 gives an active high strobe, e.g. the 4094
  assign periph_cs = ~(line_cs ^ CS_POLARITY);

  // clock and data only reach the selected line
  assign periph_sclk = line_sel & {NUM_PERIPH{spi_sclk}};
  assign periph_mosi = line_sel & {NUM_PERIPH{spi_mosi}};

  // own readback unless pass-through is selected
  assign spi_miso = spi_ss2_n ? miso_bit : |(line_sel & periph_miso);

endmodule

//--- spi_frame/spi_frame_rx.sv
// module spi_frame_rx
// host spi pin sync and edge detect, frame shift in,
// readback shift out and write command push

`timescale 1ns/100ps

module spi_frame_rx
  import spi_regs_pkg::*, spi_frame_pkg::*;
(
  input  logic      cs,
  input  logic      rst_n,
  input  logic      spi_sclk,
  input  logic      spi_ss_n,
  input  logic      spi_mosi,
  input  reg_snap_t snap,
  output logic      miso_bit,
  output logic      push,
  output wr_cmd_t   cmd
);

  // room for 16 plus saturation on long frames
  localparam int CNT_W = $clog2(FRAME_BITS) + 1;

  // [0] meta, [1] synced, [2] previous
  logic [2:0] sclk_sr;
  logic [2:0] ss_sr;
  logic [2:0] mosi_sr;

  // registered edge strobes
  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;
  logic ss_fall;

  logic [CNT_W-1:0] bit_cnt;
  frame_t           rx_sr;
  frame_t           rx_next;
  data_t            tx_sr;

  // readback value for one address
  function automatic data_t read_reg(reg_addr_t addr, reg_snap_t s);
    case (addr)
      ADDR_LED:     read_reg = {4'b0000, s.led};
      ADDR_SPI_MUX: read_reg = s.spi_mux;
      ADDR_4094:    read_reg = {4'b0000, s.out4094};
      ADDR_ADC:     read_reg = {4'b0000, s.adc};
      ADDR_STATUS:  read_reg = s.status;
      // unmapped and write only addresses
      default:      read_reg = '0;
    endcase
  endfunction

  ////////////////////
  // pin sync

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_sr <= '0;
      // chip select idles high
      ss_sr   <= '1;
      mosi_sr <= '0;
    end
    else
    begin
      sclk_sr <= {sclk_sr[1:0], spi_sclk};
      ss_sr   <= {ss_sr[1:0], spi_ss_n};
      mosi_sr <= {mosi_sr[1:0], spi_mosi};
    end
  end

  // edges seen one cycle after sync
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sclk_rise <= 1'b0;
      sclk_fall <= 1'b0;
      ss_rise   <= 1'b0;
      ss_fall   <= 1'b0;
    end
    else
    begin
      sclk_rise <= sclk_sr[1] & ~sclk_sr[2];
      sclk_fall <= ~sclk_sr[1] & sclk_sr[2];
      ss_rise   <= ss_sr[1] & ~ss_sr[2];
      ss_fall   <= ~ss_sr[1] & ss_sr[2];
    end
  end

  ////////////////////
  // frame shift

  // mosi_sr[2] lines up with the strobes
  assign rx_next = {rx_sr[FRAME_BITS-2:0], mosi_sr[2]};

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      bit_cnt <= '0;
      tx_sr   <= '0;
      push    <= 1'b0;
    end
    else
    begin
      push <= 1'b0;
      if (ss_rise || ss_fall)
      begin
        // end of frame, only a full 16 bit write goes on
        push    <= ss_rise && (bit_cnt == CNT_W'(FRAME_BITS)) && !rx_sr[RD_BIT];
        bit_cnt <= '0;
        tx_sr   <= '0;
      end
      else if (!ss_sr[2])
      begin
        if (sclk_rise)
        begin
          if (bit_cnt != '1)
          begin
            bit_cnt <= bit_cnt + 1'b1;
          end
          // 8th rise, address byte complete
          if (bit_cnt == CNT_W'(DATA_BITS - 1))
          begin
            tx_sr <= read_reg(rx_next[$bits(reg_addr_t)-1:0], snap);
          end
        end
        // mode 0 changes out on falls, skip the fall right after load
        else if (sclk_fall && (bit_cnt > CNT_W'(DATA_BITS)))
        begin
          tx_sr <= {tx_sr[DATA_BITS-2:0], 1'b0};
        end
      end
    end
  end

  // payload regs
  always_ff @(posedge cs)
  begin
    if (sclk_rise && !ss_sr[2])
    begin
      rx_sr <= rx_next;
    end
    if (ss_rise)
    begin
      cmd.addr <= rx_sr[RD_BIT-1:DATA_BITS];
      cmd.data <= rx_sr[DATA_BITS-1:0];
    end
  end

  // msb first
  assign miso_bit = tx_sr[DATA_BITS-1];

endmodule
